// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
rtl/dcache_pkg.sv
rtl/dcache_ctrl.sv
rtl/dcache_tags.sv
rtl/dcache_data.sv
rtl/fsab_req.sv
rtl/fill_seq.sv
rtl/spam_port.sv
rtl/dcache_top.sv
tests/tb_clk.sv
tests/mem_model.sv
tests/dcache_tb.sv

// ==== rtl/dcache_ctrl.sv ====
// **************************************************
// Cache control: stall, line fill start and commit,
// write issue and data array enable.
// **************************************************

`timescale 1ns/10ps

module dcache_ctrl (
	input  logic        clk,
	input  logic        rst_b,
	input  logic [31:0] addr,
	input  logic        rd_req,
	input  logic        wr_req,
	input  logic        hit,
	input  logic        credit_avail,
	input  logic        last_beat,
	input  logic        spam_wait,
	output logic        rw_wait,
	output logic        fill_start,
	output logic [31:0] fill_addr,
	output logic        fill_done_commit,
	output logic        wr_go,
	output logic        array_access
);

	dcache_pkg::ctrl_state_t state;
	logic mem_side;

	assign mem_side = !addr[31];   // Bit 31 clear is cached memory.

	// Only one line read may be outstanding at a time.
	assign fill_start = (state == dcache_pkg::IDLE) && rd_req && mem_side &&
		!hit && credit_avail;

	// The tag goes valid at the same edge that writes the last beat.
	assign fill_done_commit = (state == dcache_pkg::FILL) && last_beat;

	// Writes go straight through, one credit each.
	assign wr_go = wr_req && mem_side && credit_avail;

	assign array_access = (rd_req || wr_req) && mem_side && hit;

	always_comb begin
		if (addr[31]) begin
			rw_wait = spam_wait;   // Peripheral side decides.
		end else begin
			// A read waits for its line, a write for a credit.
			rw_wait = (rd_req && !hit) || (wr_req && !credit_avail);
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			state <= dcache_pkg::IDLE;
		end else begin
			case (state)
				dcache_pkg::IDLE: begin
					if (fill_start)
						state <= dcache_pkg::FILL;
				end
				dcache_pkg::FILL: begin
					if (last_beat)
						state <= dcache_pkg::IDLE;
				end
				default: state <= dcache_pkg::IDLE;
			endcase
		end
	end

	// Line address is frozen for the whole fill.
	always_ff @(posedge clk) begin
		if (fill_start)
			fill_addr <= {addr[31:6], 6'b0};
	end

endmodule

// ==== rtl/dcache_data.sv ====
// **************************************************
// Data store: high and low word arrays with a core
// port, a fill port and the registered read word.
// **************************************************

`timescale 1ns/10ps

module dcache_data (
	input  logic        clk,
	input  logic        rst_b,
	input  logic [31:0] addr,
	input  logic        wr_req,
	input  logic [31:0] wr_data,
	input  logic        array_access,
	input  logic [31:0] fill_addr,
	input  logic        beat_we,
	input  logic [dcache_pkg::WORD_SEL_W-1:0] beat_pos,
	input  logic [63:0] fsabi_data,
	output logic [31:0] cache_rd_data
);

	localparam int SEL_W = dcache_pkg::IDX_W + dcache_pkg::WORD_SEL_W;

	logic [31:0] data_hi [2**SEL_W];   // Indexed by {line, beat}.
	logic [31:0] data_lo [2**SEL_W];

	logic [SEL_W-1:0] core_sel;
	logic [SEL_W-1:0] fill_sel;
	logic [31:0]      rd_hi;
	logic [31:0]      rd_lo;
	logic             sel_hi;

	assign core_sel = {addr[9:6], addr[5:3]};
	assign fill_sel = {fill_addr[9:6], beat_pos};

	always_ff @(posedge clk) begin
		if (array_access && addr[2]) begin
			if (wr_req)
				data_hi[core_sel] <= wr_data;
			rd_hi <= data_hi[core_sel];
		end
		if (array_access && !addr[2]) begin
			if (wr_req)
				data_lo[core_sel] <= wr_data;
			rd_lo <= data_lo[core_sel];
		end
		if (beat_we) begin
			data_hi[fill_sel] <= fsabi_data[63:32];   // Big half first on the bus.
			data_lo[fill_sel] <= fsabi_data[31:0];
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			sel_hi <= 1'b0;
		else if (array_access)
			sel_hi <= addr[2];
	end

	assign cache_rd_data = sel_hi ? rd_hi : rd_lo;

endmodule

// ==== rtl/dcache_pkg.sv ====
// **************************************************
// Shared constants for the data cache: address field
// widths, FSAB and SPAM values, state and mode enums.
// **************************************************

package dcache_pkg;

	// Core address split: [31:10] tag, [9:6] line index, [5:3] beat, [2] half.
	localparam int TAG_W      = 22;
	localparam int IDX_W      = 4;
	localparam int WORD_SEL_W = 3;

	// FSAB request kinds.
	typedef enum logic {
		FSAB_READ  = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_mode_t;

	localparam logic [3:0] FSAB_DID_CPU       = 4'h0;   // Requester ID.
	localparam logic [3:0] FSAB_SUBDID_DCACHE = 4'h1;   // Sub-requester ID.

	localparam logic [2:0] FSAB_INITIAL_CREDITS = 3'd4;
	localparam logic [3:0] FSAB_FILL_LEN        = 4'd8;   // Beats per line read.
	localparam logic [3:0] FSAB_WRITE_LEN       = 4'd1;   // One masked beat.

	localparam logic [7:0]  SPAM_TIMEOUT   = 8'd255;
	localparam logic [31:0] SPAM_DEAD_WORD = 32'hDEADDEAD;

	// Control states for the line fill.
	typedef enum logic {
		IDLE = 1'b0,
		FILL = 1'b1
	} ctrl_state_t;

endpackage

// ==== rtl/dcache_tags.sv ====
// **************************************************
// Tag store: valid bits, tags and hit compare.
// **************************************************

`timescale 1ns/10ps

module dcache_tags (
	input  logic        clk,
	input  logic        rst_b,
	input  logic [31:0] addr,
	input  logic        fill_start,
	input  logic [31:0] fill_addr,
	input  logic        fill_done_commit,
	output logic        hit
);

	logic [(2**dcache_pkg::IDX_W)-1:0] valid;
	logic [dcache_pkg::TAG_W-1:0]      tags [2**dcache_pkg::IDX_W];

	logic [dcache_pkg::IDX_W-1:0] idx;
	logic [dcache_pkg::TAG_W-1:0] tag;
	logic [dcache_pkg::IDX_W-1:0] fill_idx;
	logic [dcache_pkg::TAG_W-1:0] fill_tag;

	assign idx      = addr[9:6];
	assign tag      = addr[31:10];
	assign fill_idx = fill_addr[9:6];
	assign fill_tag = fill_addr[31:10];

	assign hit = valid[idx] && (tags[idx] == tag);

	// The line is dropped while it is being refilled.
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			valid <= '0;
		end else if (fill_start) begin
			valid[idx] <= 1'b0;   // Fill address is not latched yet.
		end else if (fill_done_commit) begin
			valid[fill_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_done_commit)
			tags[fill_idx] <= fill_tag;
	end

endmodule

// ==== rtl/dcache_top.sv ====
// **************************************************
// Data cache top: block wiring and read data select.
// **************************************************

`timescale 1ns/10ps

module dcache_top (
	input  logic                   clk,
	input  logic                   rst_b,
	input  logic [31:0]            addr,
	input  logic                   rd_req,
	input  logic                   wr_req,
	input  logic [31:0]            wr_data,
	output logic                   rw_wait,
	output logic [31:0]            rd_data,
	output logic                   fsabo_valid,
	output dcache_pkg::fsab_mode_t fsabo_mode,
	output logic [3:0]             fsabo_did,
	output logic [3:0]             fsabo_subdid,
	output logic [30:0]            fsabo_addr,
	output logic [3:0]             fsabo_len,
	output logic [63:0]            fsabo_data,
	output logic [7:0]             fsabo_mask,
	input  logic                   fsabo_credit,
	input  logic                   fsabi_valid,
	input  logic [3:0]             fsabi_did,
	input  logic [3:0]             fsabi_subdid,
	input  logic [63:0]            fsabi_data,
	output logic                   spamo_valid,
	output logic                   spamo_r_nw,
	output logic [3:0]             spamo_did,
	output logic [23:0]            spamo_addr,
	output logic [31:0]            spamo_data,
	input  logic                   spami_busy_b,
	input  logic [31:0]            spami_data
);

	logic        hit;
	logic        credit_avail;
	logic        fill_start;
	logic [31:0] fill_addr;
	logic        fill_done_commit;
	logic        wr_go;
	logic        array_access;
	logic        beat_we;
	logic [dcache_pkg::WORD_SEL_W-1:0] beat_pos;
	logic        last_beat;
	logic        spam_wait;
	logic [31:0] spam_rd_data;
	logic [31:0] cache_rd_data;
	logic        periph_q;

	dcache_ctrl ctrl0 (
		.clk(clk), .rst_b(rst_b), .addr(addr), .rd_req(rd_req), .wr_req(wr_req),
		.hit(hit), .credit_avail(credit_avail), .last_beat(last_beat),
		.spam_wait(spam_wait), .rw_wait(rw_wait), .fill_start(fill_start),
		.fill_addr(fill_addr), .fill_done_commit(fill_done_commit),
		.wr_go(wr_go), .array_access(array_access)
	);

	dcache_tags tags0 (
		.clk(clk), .rst_b(rst_b), .addr(addr), .fill_start(fill_start),
		.fill_addr(fill_addr), .fill_done_commit(fill_done_commit), .hit(hit)
	);

	dcache_data data0 (
		.clk(clk), .rst_b(rst_b), .addr(addr), .wr_req(wr_req), .wr_data(wr_data),
		.array_access(array_access), .fill_addr(fill_addr), .beat_we(beat_we),
		.beat_pos(beat_pos), .fsabi_data(fsabi_data), .cache_rd_data(cache_rd_data)
	);

	fsab_req req0 (
		.clk(clk), .rst_b(rst_b), .addr(addr), .wr_data(wr_data),
		.fill_start(fill_start), .wr_go(wr_go), .fsabo_credit(fsabo_credit),
		.credit_avail(credit_avail), .fsabo_valid(fsabo_valid),
		.fsabo_mode(fsabo_mode), .fsabo_did(fsabo_did), .fsabo_subdid(fsabo_subdid),
		.fsabo_addr(fsabo_addr), .fsabo_len(fsabo_len), .fsabo_data(fsabo_data),
		.fsabo_mask(fsabo_mask)
	);

	fill_seq fill0 (
		.clk(clk), .rst_b(rst_b), .fill_start(fill_start), .fsabi_valid(fsabi_valid),
		.fsabi_did(fsabi_did), .fsabi_subdid(fsabi_subdid), .beat_we(beat_we),
		.beat_pos(beat_pos), .last_beat(last_beat)
	);

	spam_port spam0 (
		.clk(clk), .rst_b(rst_b), .addr(addr), .rd_req(rd_req), .wr_req(wr_req),
		.wr_data(wr_data), .spami_busy_b(spami_busy_b), .spami_data(spami_data),
		.spamo_valid(spamo_valid), .spamo_r_nw(spamo_r_nw), .spamo_did(spamo_did),
		.spamo_addr(spamo_addr), .spamo_data(spamo_data), .spam_wait(spam_wait),
		.spam_rd_data(spam_rd_data)
	);

	// Read data trails the request by one cycle, so does the side select.
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			periph_q <= 1'b0;
		else
			periph_q <= addr[31];
	end

	assign rd_data = periph_q ? spam_rd_data : cache_rd_data;

endmodule

// ==== rtl/fill_seq.sv ====
// **************************************************
// Fill beat filter and line position counter.
// **************************************************

`timescale 1ns/10ps

module fill_seq (
	input  logic                                clk,
	input  logic                                rst_b,
	input  logic                                fill_start,
	input  logic                                fsabi_valid,
	input  logic [3:0]                          fsabi_did,
	input  logic [3:0]                          fsabi_subdid,
	output logic                                beat_we,
	output logic [dcache_pkg::WORD_SEL_W-1:0]   beat_pos,
	output logic                                last_beat
);

	// Beats for other requesters pass by.
	assign beat_we = fsabi_valid && (fsabi_did == dcache_pkg::FSAB_DID_CPU) &&
		(fsabi_subdid == dcache_pkg::FSAB_SUBDID_DCACHE);

	assign last_beat = beat_we &&
		(beat_pos == dcache_pkg::WORD_SEL_W'(dcache_pkg::FSAB_FILL_LEN - 4'd1));

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			beat_pos <= '0;
		else if (fill_start)
			beat_pos <= '0;   // New line, start at beat 0.
		else if (beat_we)
			beat_pos <= beat_pos + 1'b1;
	end

endmodule

// ==== rtl/fsab_req.sv ====
// **************************************************
// FSAB request formatting and the credit counter.
// **************************************************

`timescale 1ns/10ps

module fsab_req (
	input  logic                   clk,
	input  logic                   rst_b,
	input  logic [31:0]            addr,
	input  logic [31:0]            wr_data,
	input  logic                   fill_start,
	input  logic                   wr_go,
	input  logic                   fsabo_credit,
	output logic                   credit_avail,
	output logic                   fsabo_valid,
	output dcache_pkg::fsab_mode_t fsabo_mode,
	output logic [3:0]             fsabo_did,
	output logic [3:0]             fsabo_subdid,
	output logic [30:0]            fsabo_addr,
	output logic [3:0]             fsabo_len,
	output logic [63:0]            fsabo_data,
	output logic [7:0]             fsabo_mask
);

	logic [2:0] credits;

	assign credit_avail = (credits != 3'd0);

	always_comb begin
		fsabo_valid  = 1'b0;
		fsabo_mode   = dcache_pkg::FSAB_READ;
		fsabo_did    = 4'h0;
		fsabo_subdid = 4'h0;
		fsabo_addr   = 31'h0;
		fsabo_len    = 4'h0;
		fsabo_data   = 64'h0;
		fsabo_mask   = 8'h0;
		if (fill_start) begin
			fsabo_valid  = 1'b1;
			fsabo_did    = dcache_pkg::FSAB_DID_CPU;
			fsabo_subdid = dcache_pkg::FSAB_SUBDID_DCACHE;
			fsabo_addr   = {addr[30:6], 6'b0};   // Whole line.
			fsabo_len    = dcache_pkg::FSAB_FILL_LEN;
		end else if (wr_go) begin
			fsabo_valid  = 1'b1;
			fsabo_mode   = dcache_pkg::FSAB_WRITE;
			fsabo_did    = dcache_pkg::FSAB_DID_CPU;
			fsabo_subdid = dcache_pkg::FSAB_SUBDID_DCACHE;
			fsabo_addr   = {addr[30:3], 3'b0};   // 8-byte beat.
			fsabo_len    = dcache_pkg::FSAB_WRITE_LEN;
			fsabo_data   = {wr_data, wr_data};
			fsabo_mask   = addr[2] ? 8'hF0 : 8'h0F;   // Byte lanes of the word.
		end
	end

	// Each strobe spends one credit, each return gives one back.
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			credits <= dcache_pkg::FSAB_INITIAL_CREDITS;
		else
			credits <= credits + {2'b0, fsabo_credit} - {2'b0, fsabo_valid};
	end

endmodule

// ==== rtl/spam_port.sv ====
// **************************************************
// SPAM sidechannel requests, busy wait with timeout,
// and the registered return word.
// **************************************************

`timescale 1ns/10ps

module spam_port (
	input  logic        clk,
	input  logic        rst_b,
	input  logic [31:0] addr,
	input  logic        rd_req,
	input  logic        wr_req,
	input  logic [31:0] wr_data,
	input  logic        spami_busy_b,
	input  logic [31:0] spami_data,
	output logic        spamo_valid,
	output logic        spamo_r_nw,
	output logic [3:0]  spamo_did,
	output logic [23:0] spamo_addr,
	output logic [31:0] spamo_data,
	output logic        spam_wait,
	output logic [31:0] spam_rd_data
);

	logic       in_trans;
	logic [7:0] timeout;
	logic       timed_out;
	logic [31:0] data_q;

	always_comb begin
		spamo_valid = (rd_req || wr_req) && addr[31] && !in_trans;
		spamo_r_nw  = 1'b0;
		spamo_did   = 4'h0;
		spamo_addr  = 24'h0;
		spamo_data  = 32'h0;
		if (spamo_valid) begin
			spamo_r_nw = rd_req;
			spamo_did  = addr[27:24];   // Device select.
			spamo_addr = addr[23:0];
			spamo_data = wr_req ? wr_data : 32'h0;
		end
	end

	// Hold the core until the device is ready or the count runs out.
	assign spam_wait = !spami_busy_b &&
		(spamo_valid || (in_trans && (timeout != 8'd0)));

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			in_trans  <= 1'b0;
			timeout   <= 8'd0;
			timed_out <= 1'b0;
		end else begin
			timed_out <= in_trans && (timeout == 8'd0) && !spami_busy_b;
			if (spamo_valid) begin
				in_trans <= !spami_busy_b;   // Ready at once means no wait.
				timeout  <= dcache_pkg::SPAM_TIMEOUT;
			end else if (in_trans) begin
				if (spami_busy_b || (timeout == 8'd0))
					in_trans <= 1'b0;
				else
					timeout <= timeout - 8'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		data_q <= spami_data;
	end

	assign spam_rd_data = timed_out ? dcache_pkg::SPAM_DEAD_WORD : data_q;

endmodule

// ==== tests/dcache_tb.sv ====
// **************************************************
// Data cache testbench: reset, directed tests,
// checks, run limit and summary.
// **************************************************

`timescale 1ns/10ps

module dcache_tb;

	localparam int RESET_LEN = 10;
	localparam int TESTS_LEN = 30 + 10 + 30 + 160 + 30 + 265;
	localparam int RUN_LIMIT = (RESET_LEN + TESTS_LEN) * 3 / 2;   // 50% margin.

	logic clk, rst_b, rd_req, wr_req, rw_wait, fsabo_valid, fsabo_credit;
	logic fsabi_valid, spamo_valid, spamo_r_nw, spami_busy_b;
	logic [31:0] addr, wr_data, rd_data, spamo_data, spami_data;
	dcache_pkg::fsab_mode_t fsabo_mode;
	logic [3:0] fsabo_did, fsabo_subdid, fsabo_len, fsabi_did, fsabi_subdid, spamo_did;
	logic [30:0] fsabo_addr;
	logic [63:0] fsabo_data, fsabi_data;
	logic [7:0]  fsabo_mask;
	logic [23:0] spamo_addr;
	int credit_delay, busy_cycles, cycles, checks, errors, req_count;
	dcache_pkg::fsab_mode_t last_mode;
	logic [3:0]  last_did;
	logic [3:0]  last_subdid;
	logic [30:0] last_addr;
	logic [3:0]  last_len;
	logic [63:0] last_data;
	logic [7:0]  last_mask;
	logic        first_valid, first_r_nw;
	logic [3:0]  first_did;
	logic [23:0] first_addr;
	logic [31:0] first_data;

	tb_clk clk0 (.clk(clk));

	dcache_top dut0 (.*);

	mem_model mem0 (.*);

	// Outbound request log.
	always @(negedge clk) begin
		if (fsabo_valid) begin
			req_count++;
			last_mode   = fsabo_mode;
			last_did    = fsabo_did;
			last_subdid = fsabo_subdid;
			last_addr   = fsabo_addr;
			last_len    = fsabo_len;
			last_data   = fsabo_data;
			last_mask   = fsabo_mask;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > RUN_LIMIT) begin
			errors++;
			$display("Run limit of %0d cycles reached, the DUT stopped responding", RUN_LIMIT);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic logic [31:0] init_word(input logic [31:0] a);
		return a[2] ? {a[31:3], 3'h5} : {a[31:3], 3'h2};
	endfunction

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Error: %s is %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("%s", what);
		end
	endtask

	// One core access held until rw_wait drops; read data taken a cycle later.
	task automatic access(input logic wr, input logic [31:0] a, input logic [31:0] d,
		output int stall, output logic [31:0] rdat);
		@(posedge clk);
		addr    <= a;
		rd_req  <= !wr;
		wr_req  <= wr;
		wr_data <= d;
		stall = 0;
		@(negedge clk);
		first_valid = spamo_valid;
		first_r_nw  = spamo_r_nw;
		first_did   = spamo_did;
		first_addr  = spamo_addr;
		first_data  = spamo_data;
		while (rw_wait) begin
			stall++;
			@(negedge clk);
		end
		@(posedge clk);
		rd_req <= 1'b0;
		wr_req <= 1'b0;
		@(negedge clk);
		rdat = rd_data;
	endtask

	task automatic read_miss_then_hit(input logic [31:0] a);
		int n0, st;
		logic [31:0] rd;
		n0 = req_count;
		access(1'b0, a, 32'h0, st, rd);
		check_val("req_count", req_count, n0 + 1);
		check_val("fsabo_mode", last_mode, dcache_pkg::FSAB_READ);
		check_val("fsabo_did", last_did, dcache_pkg::FSAB_DID_CPU);
		check_val("fsabo_subdid", last_subdid, dcache_pkg::FSAB_SUBDID_DCACHE);
		check_val("fsabo_addr", last_addr, {a[30:6], 6'b0});
		check_val("fsabo_len", last_len, 4'd8);
		check_val("rd_data", rd, init_word(a));
		access(1'b0, a ^ 32'h4, 32'h0, st, rd);
		check_true(st == 0, "Read of a cached line stalled");
		check_val("req_count", req_count, n0 + 1);
		check_val("rd_data", rd, init_word(a ^ 32'h4));
	endtask

	task automatic write_then_read(input logic [31:0] a, input logic [31:0] d, input logic miss);
		int n0, st;
		logic [31:0] rd;
		n0 = req_count;
		access(1'b1, a, d, st, rd);
		check_val("req_count", req_count, n0 + 1);
		check_val("fsabo_mode", last_mode, dcache_pkg::FSAB_WRITE);
		check_val("fsabo_did", last_did, dcache_pkg::FSAB_DID_CPU);
		check_val("fsabo_subdid", last_subdid, dcache_pkg::FSAB_SUBDID_DCACHE);
		check_val("fsabo_addr", last_addr, {a[30:3], 3'b0});
		check_val("fsabo_data", last_data, {d, d});
		check_val("fsabo_mask", last_mask, a[2] ? 8'hF0 : 8'h0F);
		access(1'b0, a, 32'h0, st, rd);
		check_val("req_count", req_count, n0 + 1 + (miss ? 1 : 0));
		check_true((st != 0) == miss, "Read after write stalled differently than expected");
		check_val("rd_data", rd, d);
	endtask

	task automatic credit_stall(input logic [31:0] a);
		int n0, st;
		logic [31:0] rd;
		credit_delay = 60;
		n0 = req_count;
		for (int i = 0; i < 4; i++) begin
			access(1'b1, a + 32'(i * 8), 32'h1000 + 32'(i), st, rd);
			check_true(st == 0, "Write with credits left stalled");
		end
		access(1'b1, a + 32'h40, 32'h2000, st, rd);
		check_true(st != 0, "Fifth write without credits did not stall");
		check_val("req_count", req_count, n0 + 5);
		credit_delay = 2;
		repeat (70) @(posedge clk);
	endtask

	task automatic spam_access(input int busy, input logic [31:0] a, input logic [31:0] exp);
		int st;
		logic [31:0] rd;
		busy_cycles = busy;
		repeat (2) @(posedge clk);   // Let the device reload its busy count.
		access(1'b1, a, 32'h5A5A_0001, st, rd);
		check_true(first_valid, "SPAM write gave no spamo_valid");
		check_val("spamo_r_nw", first_r_nw, 1'b0);
		check_val("spamo_did", first_did, a[27:24]);
		check_val("spamo_addr", first_addr, a[23:0]);
		check_val("spamo_data", first_data, 32'h5A5A_0001);
		repeat (busy + 3) @(posedge clk);
		access(1'b0, a, 32'h0, st, rd);
		check_true(st != 0, "SPAM read did not wait for busy");
		check_val("rd_data", rd, exp);
	endtask

	task automatic spam_timeout(input logic [31:0] a);
		int st;
		logic [31:0] rd;
		busy_cycles = 300;
		repeat (2) @(posedge clk);
		access(1'b0, a, 32'h0, st, rd);
		check_val("rd_data", rd, 32'hDEADDEAD);
	endtask

	initial begin
		logic [31:0] r1, r2, a1;
		void'($urandom(32'h7d84));
		{cycles, checks, errors, req_count} = '0;
		{rd_req, wr_req, addr, wr_data} = '0;
		credit_delay = 2;
		busy_cycles  = 5;
		rst_b = 1'b0;
		repeat (RESET_LEN) @(posedge clk);
		rst_b <= 1'b1;
		r1 = $urandom();
		r2 = $urandom();
		a1 = {1'b0, r1[30:2], 2'b00};
		read_miss_then_hit(a1);
		write_then_read(a1, r2, 1'b0);
		write_then_read(a1 ^ 32'h400, ~r2, 1'b1);   // Same line index, other tag.
		credit_stall({1'b0, r2[30:9], 9'h0});
		spam_access(5, 32'h8300_1234, 32'h0000_1234 ^ 32'h00A5_0000);
		spam_timeout(32'h8100_0A3C);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== tests/mem_model.sv ====
// **************************************************
// FSAB memory with delayed credit return, and a SPAM
// device with a programmable busy time.
// **************************************************

`timescale 1ns/10ps

module mem_model (
	input  logic                   clk,
	input  logic                   rst_b,
	input  int                     credit_delay,
	input  int                     busy_cycles,
	input  logic                   fsabo_valid,
	input  dcache_pkg::fsab_mode_t fsabo_mode,
	input  logic [30:0]            fsabo_addr,
	input  logic [63:0]            fsabo_data,
	input  logic [7:0]             fsabo_mask,
	output logic                   fsabo_credit,
	output logic                   fsabi_valid,
	output logic [3:0]             fsabi_did,
	output logic [3:0]             fsabi_subdid,
	output logic [63:0]            fsabi_data,
	input  logic                   spamo_valid,
	input  logic [23:0]            spamo_addr,
	output logic                   spami_busy_b,
	output logic [31:0]            spami_data
);

	logic [63:0] mem [logic [30:0]];   // Only written beats are stored.
	int          due_q [$];
	int          cyc;
	int          fill_delay;
	int          beats_left;
	logic [30:0] fill_base;
	logic        active;
	int          busy_left;
	logic [23:0] dev_addr;

	function automatic logic [63:0] read_beat(input logic [30:0] a);
		logic [31:0] full;
		full = {1'b0, a};
		if (mem.exists(a))
			return mem[a];
		return {full[31:3], 3'h5, full[31:3], 3'h2};
	endfunction

	assign fsabi_did    = dcache_pkg::FSAB_DID_CPU;
	assign fsabi_subdid = dcache_pkg::FSAB_SUBDID_DCACHE;

	always @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			cyc          <= 0;
			fill_delay   <= 0;
			beats_left   <= 0;
			fill_base    <= '0;
			fsabi_valid  <= 1'b0;
			fsabi_data   <= '0;
			fsabo_credit <= 1'b0;
		end else begin
			cyc          <= cyc + 1;
			fsabi_valid  <= 1'b0;
			fsabo_credit <= 1'b0;
			if (fill_delay != 0) begin
				fill_delay <= fill_delay - 1;
			end else if (beats_left != 0) begin
				fsabi_valid <= 1'b1;
				fsabi_data  <= read_beat(fill_base + 31'((8 - beats_left) * 8));
				beats_left  <= beats_left - 1;
			end
			if (fsabo_valid) begin
				due_q.push_back(cyc + credit_delay);
				if (fsabo_mode == dcache_pkg::FSAB_READ) begin
					fill_base  <= fsabo_addr;
					fill_delay <= 2;   // First beat 3 cycles on.
					beats_left <= 8;
				end else begin
					mem[fsabo_addr] = read_beat(fsabo_addr);
					for (int i = 0; i < 8; i++)
						if (fsabo_mask[i])
							mem[fsabo_addr][i*8 +: 8] = fsabo_data[i*8 +: 8];
				end
			end
			if (due_q.size() > 0 && due_q[0] <= cyc) begin
				fsabo_credit <= 1'b1;   // One credit per cycle.
				void'(due_q.pop_front());
			end
		end
	end

	// SPAM device, busy from the request cycle for busy_cycles cycles.
	always @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			active    <= 1'b0;
			busy_left <= 1;
			dev_addr  <= '0;
		end else if (!active) begin
			busy_left <= busy_cycles;
			if (spamo_valid) begin
				active    <= 1'b1;
				busy_left <= (busy_cycles > 0) ? busy_cycles - 1 : 0;
				dev_addr  <= spamo_addr;
			end
		end else if (busy_left != 0) begin
			busy_left <= busy_left - 1;
		end else begin
			active <= 1'b0;
		end
	end

	assign spami_busy_b = (busy_left == 0);
	assign spami_data   = {8'h0, spamo_valid ? spamo_addr : dev_addr} ^ 32'h00A5_0000;

endmodule

// ==== tests/tb_clk.sv ====
// **************************************************
// Free running testbench clock, 4 ns period.
// **************************************************

`timescale 1ns/10ps

module tb_clk (
	output logic clk
);

	initial clk = 1'b0;

	always #2 clk = ~clk;

endmodule
